/* verilog.f */
+incdir+hw
hw/ltssmPkg.sv
hw/lanePkg.sv
hw/laneStatusIf.sv
hw/cfgLaneTracker.sv
hw/cfgWidthResolver.sv
hw/cfgSubstateCtrl.sv
hw/ltssmConfig.sv
tests/ltssmConfig_properties.sv
tests/ltssmConfigTb.sv

/* Bender.yml */
package:
  name: ltssm_config

sources:
  - include_dirs:
      - hw
    files:
      - hw/ltssmPkg.sv
      - hw/lanePkg.sv
      - hw/laneStatusIf.sv
      - hw/cfgLaneTracker.sv
      - hw/cfgWidthResolver.sv
      - hw/cfgSubstateCtrl.sv
      - hw/ltssmConfig.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/ltssmConfig_properties.sv
      - tests/ltssmConfigTb.sv

/* tests/ltssmConfigTb.sv */
module ltssmConfigTb
    import ltssmPkg::*;
    import lanePkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    // Four scenarios of about one timeout plus handshakes, with margin
    localparam int MaxCycles = 2000;

    logic       sys_clk = 1'b0;
    logic       rst_n;
    logic       inConfig;
    laneMask    laneDetected;
    laneMask    rxTs1;
    laneMask    rxTs2;
    laneMask    rxLinkOk;
    laneMask    rxLaneOk;
    laneMask    rxIdle;
    osKind      txOs;
    laneMask    txLaneMask;
    logic [7:0] txLinkNum;
    linkWidth   linkWidthOut;
    logic       linkUp;
    logic       exitDetect;
    cfgState    cfgStateOut;
    int         cycleCount = 0;

    ltssmConfig dut_i (.*);

    always #50 sys_clk = ~sys_clk;

    always @(posedge sys_clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= MaxCycles) begin
            $display("Regression failed");
            $fatal(1, "Run did not finish within %0d cycles", MaxCycles);
        end
    end

    // Bound checker counts its assertion failures
    always @(negedge sys_clk) begin
        if (dut_i.propCheck.failCount != 0) begin
            $display("Regression failed");
            $fatal(1, "A concurrent assertion on the DUT failed");
        end
    end

    task automatic randomPause();
        int unsigned n;
        n = $urandom % 4;
        repeat (n) @(posedge sys_clk);
    endtask

    task automatic waitOs(input osKind os);
        do begin
            @(negedge sys_clk);
        end while (txOs != os);
    endtask

    task automatic startTraining(input laneMask detected);
        @(posedge sys_clk);
        laneDetected <= detected;
        inConfig     <= 1'b1;
    endtask

    // Partner returns link and lane numbers with its TS1
    task automatic answerTs1(input laneMask lanes);
        waitOs(OsTs1);
        randomPause();
        @(posedge sys_clk);
        rxTs1    <= lanes;
        rxLinkOk <= lanes;
        rxLaneOk <= lanes;
    endtask

    task automatic trainLink(input laneMask detected, input laneMask lanes);
        startTraining(detected);
        answerTs1(lanes);
        waitOs(OsTs2);
        randomPause();
        @(posedge sys_clk);
        rxTs2 <= lanes;
        waitOs(OsIdle);
        randomPause();
        @(posedge sys_clk);
        rxIdle <= lanes;
        do begin
            @(negedge sys_clk);
        end while (!linkUp);
    endtask

    task automatic leaveConfig();
        @(posedge sys_clk);
        inConfig <= 1'b0;
        rxTs1    <= '0;
        rxTs2    <= '0;
        rxLinkOk <= '0;
        rxLaneOk <= '0;
        rxIdle   <= '0;
        repeat (3) @(posedge sys_clk);
    endtask

    initial begin
        void'($urandom(53048));
        rst_n        = 1'b0;
        inConfig     = 1'b0;
        laneDetected = '0;
        rxTs1        = '0;
        rxTs2        = '0;
        rxLinkOk     = '0;
        rxLaneOk     = '0;
        rxIdle       = '0;
        repeat (4) @(posedge sys_clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge sys_clk);

        trainLink(4'b1111, 4'b1111);
        leaveConfig();
        trainLink(4'b1111, 4'b0011); // Lanes 2 and 3 never take the link number
        leaveConfig();

        // Silent partner
        startTraining(4'b1111);
        do begin
            @(negedge sys_clk);
        end while (!exitDetect);
        repeat (2) @(negedge sys_clk);
        leaveConfig();

        startTraining(4'b0001);
        answerTs1(4'b0001);
        waitOs(OsTs2);
        leaveConfig(); // Abort in mid-training
        @(negedge sys_clk);

        if (dut_i.propCheck.failCount == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Regression failed");
            $fatal(1, "A concurrent assertion on the DUT failed");
        end
    end

endmodule

/* tests/ltssmConfig_properties.sv */
`include "ltssm_defines.svh"

module ltssmConfigProps
    import ltssmPkg::*;
    import lanePkg::*;
(
    input logic       sys_clk,
    input logic       rst_n,
    input logic       inConfig,
    input laneMask    laneDetected,
    input laneMask    rxLinkOk,
    input osKind      txOs,
    input laneMask    txLaneMask,
    input logic [7:0] txLinkNum,
    input linkWidth   linkWidthOut,
    input logic       linkUp,
    input logic       exitDetect,
    input cfgState    cfgStateOut
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned failCount = 0; // Polled by the testbench
    cfgState     lastState;
    logic [7:0]  heldCnt;       // Cycles the current state has been held
    laneMask     qualD1;
    linkWidth    expWidth;

    function automatic osKind osFor(cfgState s);
        case (s)
            WidthStart, WidthAccept, LaneWait: return OsTs1;
            LaneAccept, Complete:              return OsTs2;
            IdleWait, LinkUp:                  return OsIdle;
            default:                           return OsNone;
        endcase
    endfunction

    // Widest group from lane 0 that took the link number
    function automatic linkWidth widthFor(laneMask qual);
        if (qual == 4'b1111) return WidthX4;
        if (qual[1:0] == 2'b11) return WidthX2;
        if (qual[0]) return WidthX1;
        return WidthNone;
    endfunction

    function automatic laneMask maskFor(linkWidth w);
        case (w)
            WidthX4: return 4'b1111;
            WidthX2: return 4'b0011;
            WidthX1: return 4'b0001;
            default: return 4'b0000;
        endcase
    endfunction

    task automatic countFailure(input string msg);
        failCount++;
        $error("%s", msg);
    endtask

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            lastState <= Off;
            heldCnt   <= '0;
            qualD1    <= '0;
            expWidth  <= WidthNone;
        end else begin
            lastState <= cfgStateOut;
            if (cfgStateOut != lastState) begin
                heldCnt <= '0;
            end else if (heldCnt != '1) begin
                heldCnt <= heldCnt + 1'b1;
            end
            qualD1 <= laneDetected & rxLinkOk;
            // Resolver registers once, controller latches on leaving WidthStart
            if (cfgStateOut == WidthStart) begin
                expWidth <= widthFor(qualD1);
            end
        end
    end

    resetValues: assert property (@(posedge sys_clk) $rose(rst_n) |-> cfgStateOut == Off
        && txOs == OsNone && txLaneMask == '0 && !linkUp && !exitDetect
        && linkWidthOut == WidthNone)
        else countFailure($sformatf("[ERROR] reset outputs: state=%h txOs=%h mask=%h width=%h",
            $sampled(cfgStateOut), $sampled(txOs), $sampled(txLaneMask), $sampled(linkWidthOut)));

    osRule: assert property (@(posedge sys_clk) disable iff (!rst_n) txOs == osFor(cfgStateOut))
        else countFailure($sformatf("[ERROR] txOs: got %h, expected %h",
            $sampled(txOs), osFor($sampled(cfgStateOut))));

    linkNumRule: assert property (@(posedge sys_clk) disable iff (!rst_n) txLinkNum == 8'h00)
        else countFailure($sformatf("[ERROR] txLinkNum: got %h, expected %h",
            $sampled(txLinkNum), 8'h00));

    startMask: assert property (@(posedge sys_clk) disable iff (!rst_n)
        cfgStateOut == WidthStart |-> txLaneMask == laneDetected)
        else countFailure($sformatf("[ERROR] txLaneMask: got %h, expected %h",
            $sampled(txLaneMask), $sampled(laneDetected)));

    widthRule: assert property (@(posedge sys_clk) disable iff (!rst_n)
        cfgStateOut inside {WidthAccept, LaneWait, LaneAccept, Complete, IdleWait, LinkUp}
        |-> expWidth != WidthNone && linkWidthOut == expWidth)
        else countFailure($sformatf("[ERROR] linkWidthOut: got %h, expected %h",
            $sampled(linkWidthOut), $sampled(expWidth)));

    maskRule: assert property (@(posedge sys_clk) disable iff (!rst_n)
        cfgStateOut inside {WidthAccept, LaneWait, LaneAccept, Complete, IdleWait, LinkUp}
        |-> txLaneMask == maskFor(expWidth))
        else countFailure($sformatf("[ERROR] txLaneMask: got %h, expected %h",
            $sampled(txLaneMask), maskFor($sampled(expWidth))));

    exitAfterTimeout: assert property (@(posedge sys_clk) disable iff (!rst_n)
        exitDetect |-> cfgStateOut == Exit && !linkUp && heldCnt >= `CFG_TIMEOUT_CYCLES
        && lastState inside {WidthStart, LaneWait, Complete, IdleWait})
        else countFailure($sformatf("exitDetect came after %0d cycles in state %h",
            $sampled(heldCnt), $sampled(lastState)));

    exitPulse: assert property (@(posedge sys_clk) disable iff (!rst_n)
        exitDetect |=> !exitDetect && cfgStateOut == Off)
        else countFailure("exitDetect was not a single pulse followed by Off");

    abortToOff: assert property (@(posedge sys_clk) disable iff (!rst_n)
        !inConfig |=> cfgStateOut == Off)
        else countFailure($sformatf("[ERROR] cfgStateOut: got %h, expected %h",
            $sampled(cfgStateOut), Off));

endmodule

bind ltssmConfig ltssmConfigProps propCheck (.*);

/* hw/ltssmConfig.sv */
`include "ltssm_defines.svh"

module ltssmConfig
    import ltssmPkg::*;
    import lanePkg::*;
(
    input  logic       sys_clk,
    input  logic       rst_n,
    input  logic       inConfig,
    input  laneMask    laneDetected,
    input  laneMask    rxTs1,
    input  laneMask    rxTs2,
    input  laneMask    rxLinkOk,
    input  laneMask    rxLaneOk,
    input  laneMask    rxIdle,
    output osKind      txOs,
    output laneMask    txLaneMask,
    output logic [7:0] txLinkNum,
    output linkWidth   linkWidthOut,
    output logic       linkUp,
    output logic       exitDetect,
    output cfgState    cfgStateOut
);

    logic     clearSeen;
    linkWidth resolvedWidth;
    laneMask  resolvedMask;

    laneStatusIf statusIf ();

    cfgLaneTracker uTracker (
        .sys_clk      (sys_clk),
        .rst_n        (rst_n),
        .laneDetected (laneDetected),
        .rxTs1        (rxTs1),
        .rxTs2        (rxTs2),
        .rxLinkOk     (rxLinkOk),
        .rxLaneOk     (rxLaneOk),
        .rxIdle       (rxIdle),
        .clearSeen    (clearSeen),
        .status       (statusIf.tracker)
    );

    cfgWidthResolver uResolver (
        .sys_clk       (sys_clk),
        .rst_n         (rst_n),
        .laneDetected  (laneDetected),
        .rxLinkOk      (rxLinkOk),
        .resolvedWidth (resolvedWidth),
        .resolvedMask  (resolvedMask)
    );

    cfgSubstateCtrl uCtrl (
        .sys_clk       (sys_clk),
        .rst_n         (rst_n),
        .inConfig      (inConfig),
        .laneDetected  (laneDetected),
        .status        (statusIf.ctrl),
        .resolvedWidth (resolvedWidth),
        .resolvedMask  (resolvedMask),
        .clearSeen     (clearSeen),
        .txOs          (txOs),
        .txLaneMask    (txLaneMask),
        .linkWidthOut  (linkWidthOut),
        .linkUp        (linkUp),
        .exitDetect    (exitDetect),
        .cfgStateOut   (cfgStateOut)
    );

    assign txLinkNum = `LINK_NUM; // Fixed link number

endmodule

/* hw/cfgSubstateCtrl.sv */
`include "ltssm_defines.svh"

module cfgSubstateCtrl
    import ltssmPkg::*;
    import lanePkg::*;
(
    input  logic     sys_clk,
    input  logic     rst_n,
    input  logic     inConfig,
    input  laneMask  laneDetected,
    laneStatusIf.ctrl status,
    input  linkWidth resolvedWidth,
    input  laneMask  resolvedMask,
    output logic     clearSeen,
    output osKind    txOs,
    output laneMask  txLaneMask,
    output linkWidth linkWidthOut,
    output logic     linkUp,
    output logic     exitDetect,
    output cfgState  cfgStateOut
);

    localparam int WaitWidth = $clog2(`CFG_TIMEOUT_CYCLES + 1);

    cfgState              state;
    cfgState              stateNext;
    logic [WaitWidth-1:0] waitCnt;
    logic                 timeout;
    logic                 fresh;
    linkWidth             widthQ;
    laneMask              maskQ;

    function automatic logic covers(laneMask seen, laneMask need);
        return (seen & need) == need;
    endfunction

    assign timeout = (waitCnt == WaitWidth'(`CFG_TIMEOUT_CYCLES));
    assign fresh   = !clearSeen; // Seen flags still hold the old substate

    always_comb begin
        stateNext = state;
        if (!inConfig) begin
            stateNext = Off; // Abort from anywhere
        end else begin
            case (state)
                Off: stateNext = WidthStart;
                WidthStart: begin
                    if (timeout) begin
                        stateNext = Exit;
                    end else if (resolvedWidth != WidthNone) begin
                        stateNext = WidthAccept;
                    end
                end
                WidthAccept: stateNext = LaneWait;
                LaneWait: begin
                    if (timeout) begin
                        stateNext = Exit;
                    end else if (fresh && covers(status.laneSeen, maskQ)) begin
                        stateNext = LaneAccept;
                    end
                end
                LaneAccept: stateNext = Complete;
                Complete: begin
                    if (timeout) begin
                        stateNext = Exit;
                    end else if (fresh && covers(status.ts2Seen, maskQ)) begin
                        stateNext = IdleWait;
                    end
                end
                IdleWait: begin
                    if (timeout) begin
                        stateNext = Exit;
                    end else if (fresh && covers(status.idleSeen, maskQ)) begin
                        stateNext = LinkUp;
                    end
                end
                LinkUp:  stateNext = LinkUp;
                Exit:    stateNext = Off;
                default: stateNext = Off;
            endcase
        end
    end

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= Off;
            clearSeen <= 1'b0;
            waitCnt   <= '0;
        end else begin
            state     <= stateNext;
            clearSeen <= (stateNext != state); // High in the new state's first cycle
            if (stateNext != state) begin
                waitCnt <= '0;
            end else if (!timeout) begin
                waitCnt <= waitCnt + 1'b1;
            end
        end
    end

    // Width is frozen on the way into WidthAccept
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            widthQ <= WidthNone;
            maskQ  <= '0;
        end else if (state == WidthStart && stateNext == WidthAccept) begin
            widthQ <= resolvedWidth;
            maskQ  <= resolvedMask;
        end
    end

    always_comb begin
        case (state)
            WidthStart: begin
                txOs         = OsTs1;
                txLaneMask   = laneDetected;
                linkWidthOut = WidthNone;
            end
            WidthAccept, LaneWait: begin
                txOs         = OsTs1;
                txLaneMask   = maskQ;
                linkWidthOut = widthQ;
            end
            LaneAccept, Complete: begin
                txOs         = OsTs2;
                txLaneMask   = maskQ;
                linkWidthOut = widthQ;
            end
            IdleWait, LinkUp: begin
                txOs         = OsIdle;
                txLaneMask   = maskQ;
                linkWidthOut = widthQ;
            end
            default: begin // Off and Exit
                txOs         = OsNone;
                txLaneMask   = '0;
                linkWidthOut = WidthNone;
            end
        endcase
    end

    assign linkUp      = (state == LinkUp);
    assign exitDetect  = (state == Exit); // Exit lasts one cycle
    assign cfgStateOut = state;

endmodule

/* hw/cfgWidthResolver.sv */
module cfgWidthResolver
    import lanePkg::*;
(
    input  logic     sys_clk,
    input  logic     rst_n,
    input  laneMask  laneDetected,
    input  laneMask  rxLinkOk,
    output linkWidth resolvedWidth,
    output laneMask  resolvedMask
);

    localparam laneMask MaskX4 = '1;
    localparam laneMask MaskX2 = laneMask'(2'b11);
    localparam laneMask MaskX1 = laneMask'(1'b1);

    laneMask  qualified;
    linkWidth widthNext;
    laneMask  maskNext;

    assign qualified = laneDetected & rxLinkOk;

    // Widest group starting at lane 0
    always_comb begin
        if (&qualified) begin
            widthNext = WidthX4;
            maskNext  = MaskX4;
        end else if ((qualified & MaskX2) == MaskX2) begin
            widthNext = WidthX2;
            maskNext  = MaskX2;
        end else if (qualified[0]) begin
            widthNext = WidthX1;
            maskNext  = MaskX1;
        end else begin
            widthNext = WidthNone;
            maskNext  = '0;
        end
    end

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            resolvedWidth <= WidthNone;
            resolvedMask  <= '0;
        end else begin
            resolvedWidth <= widthNext;
            resolvedMask  <= maskNext;
        end
    end

endmodule

/* hw/cfgLaneTracker.sv */
module cfgLaneTracker
    import lanePkg::*;
(
    input  logic    sys_clk,
    input  logic    rst_n,
    input  laneMask laneDetected,
    input  laneMask rxTs1,
    input  laneMask rxTs2,
    input  laneMask rxLinkOk,
    input  laneMask rxLaneOk,
    input  laneMask rxIdle,
    input  logic    clearSeen,
    laneStatusIf.tracker status
);

    laneMask ts1Q;
    laneMask ts2Q;
    laneMask linkQ;
    laneMask laneQ;
    laneMask idleQ;

    // Undetected lanes never count
    laneMask ts1Hit;
    laneMask ts2Hit;
    laneMask linkHit;
    laneMask laneHit;
    laneMask idleHit;

    assign ts1Hit  = rxTs1 & laneDetected;
    assign ts2Hit  = rxTs2 & laneDetected;
    assign linkHit = rxLinkOk & laneDetected;
    assign laneHit = rxLaneOk & laneDetected;
    assign idleHit = rxIdle & laneDetected;

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            ts1Q  <= '0;
            ts2Q  <= '0;
            linkQ <= '0;
            laneQ <= '0;
            idleQ <= '0;
        end else if (clearSeen) begin // Clear beats a same-cycle hit
            ts1Q  <= '0;
            ts2Q  <= '0;
            linkQ <= '0;
            laneQ <= '0;
            idleQ <= '0;
        end else begin
            ts1Q  <= ts1Q | ts1Hit;
            ts2Q  <= ts2Q | ts2Hit;
            linkQ <= linkQ | linkHit;
            laneQ <= laneQ | laneHit;
            idleQ <= idleQ | idleHit;
        end
    end

    assign status.ts1Seen  = ts1Q;
    assign status.ts2Seen  = ts2Q;
    assign status.linkSeen = linkQ;
    assign status.laneSeen = laneQ;
    assign status.idleSeen = idleQ;

endmodule

/* hw/laneStatusIf.sv */
interface laneStatusIf
    import lanePkg::*;
();

    // Sticky since the last substate change
    laneMask ts1Seen;
    laneMask ts2Seen;
    laneMask linkSeen;
    laneMask laneSeen;
    laneMask idleSeen;

    modport tracker (
        output ts1Seen,
        output ts2Seen,
        output linkSeen,
        output laneSeen,
        output idleSeen
    );

    modport ctrl (
        input ts1Seen,
        input ts2Seen,
        input linkSeen,
        input laneSeen,
        input idleSeen
    );

endinterface

/* hw/lanePkg.sv */
`include "ltssm_defines.svh"

package lanePkg;

    typedef logic [`LANE_COUNT-1:0] laneMask; // One bit per lane

    // Negotiated width
    typedef enum logic [1:0] {
        WidthNone,
        WidthX1,
        WidthX2,
        WidthX4
    } linkWidth;

endpackage

/* hw/ltssmPkg.sv */
package ltssmPkg;

    // Configuration substates
    typedef enum logic [3:0] {
        Off,
        WidthStart,
        WidthAccept,
        LaneWait,
        LaneAccept,
        Complete,
        IdleWait,
        LinkUp,
        Exit
    } cfgState;

    // Ordered set on the transmit lanes
    typedef enum logic [1:0] {
        OsNone,
        OsTs1,
        OsTs2,
        OsIdle
    } osKind;

endpackage

/* hw/ltssm_defines.svh */
`ifndef LTSSM_DEFINES_SVH
`define LTSSM_DEFINES_SVH

// Lanes on the link
`define LANE_COUNT 4

// Cycles a waiting substate may spend before the exit to Detect
`define CFG_TIMEOUT_CYCLES 64

// Link number sent in the TS fields
`define LINK_NUM 8'd0

`endif
